//--- Makefile
# Verilator build for the instruction cache
# every variable can be overridden on the command line

VERILATOR  ?= verilator
FILELIST   ?= icache.f
TB_TOP     ?= tb_icache
RTL_TOP    ?= icache_top
OBJ_DIR    ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --timing --assert
PASS_MSG   ?= Simulation finished: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(OBJ_DIR)

# the run passes only if the pass line shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- design/icache_arrays.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_arrays (
  input  wire                      clk_i,
  input  wire                      rst_ni,
  // access control from the controller
  input  wire                      cache_rden_i,
  input  wire                      cache_wren_i,
  input  wire                      flush_en_i,
  input  wire icache_pkg::index_t  index_i,
  input  wire icache_pkg::tag_t    tag_i,
  input  wire icache_pkg::offset_t offset_i,
  input  wire                      cmp_en_i,
  // way picked for the refill
  input  wire icache_pkg::way_oh_t victim_oh_i,
  input  wire icache_pkg::line_t   rtrn_data_i,
  output icache_pkg::way_oh_t      hit_o,
  output icache_pkg::way_oh_t      valid_o,
  output logic                     flush_done_o,
  output icache_pkg::word_t        word_o
);

  // valid bits of all ways live together, one entry per set
  icache_pkg::way_oh_t valid_mem [`ICACHE_SETS];
  icache_pkg::way_oh_t valid_rd_q;
  icache_pkg::index_t  vld_addr;
  icache_pkg::index_t  flush_cnt_q;
  icache_pkg::word_t   way_word [`ICACHE_WAYS];
  logic [`ICACHE_OFFSET_WIDTH-3:0] word_sel;

  // word number inside the line
  assign word_sel = offset_i[`ICACHE_OFFSET_WIDTH-1:2];

  ////////////////////
  // flush counter
  ////////////////////

  assign flush_done_o = (flush_cnt_q == icache_pkg::index_t'(`ICACHE_SETS - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_cnt_q <= '0;
    end else if (flush_en_i) begin
      // wraps after the last set so the next flush starts at zero
      flush_cnt_q <= flush_done_o ? '0 : flush_cnt_q + 1'b1;
    end
  end

  ////////////////////
  // valid bits
  ////////////////////

  // during a flush the counter walks the sets
  assign vld_addr = flush_en_i ? flush_cnt_q : index_i;

  always_ff @(posedge clk_i) begin
    if (flush_en_i) begin
      valid_mem[vld_addr] <= '0;
    end else if (cache_wren_i) begin
      valid_mem[vld_addr] <= valid_mem[vld_addr] | victim_oh_i;
    end
    if (cache_rden_i) begin
      valid_rd_q <= valid_mem[vld_addr];
    end
  end

  assign valid_o = valid_rd_q;

  ////////////////////
  // tag and data
  ////////////////////

  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : gen_way
    icache_pkg::tag_t  tag_mem [`ICACHE_SETS];
    icache_pkg::line_t data_mem [`ICACHE_SETS];
    icache_pkg::tag_t  tag_rd_q;
    icache_pkg::line_t data_rd_q;

    // only the victim way takes the refilled line
    always_ff @(posedge clk_i) begin
      if (cache_wren_i && victim_oh_i[w]) begin
        tag_mem[index_i]  <= tag_i;
        data_mem[index_i] <= rtrn_data_i;
      end
      if (cache_rden_i) begin
        tag_rd_q  <= tag_mem[index_i];
        data_rd_q <= data_mem[index_i];
      end
    end

    // tag compare in the cycle after the read
    assign hit_o[w] = valid_rd_q[w] & (tag_rd_q == tag_i);
    assign way_word[w] = data_rd_q[word_sel*`ICACHE_FETCH_WIDTH +: `ICACHE_FETCH_WIDTH];
  end

  // hit vector is one-hot, so an and-or select is enough
  // outside a compare the word comes straight from the refill
  always_comb begin
    word_o = rtrn_data_i[word_sel*`ICACHE_FETCH_WIDTH +: `ICACHE_FETCH_WIDTH];
    if (cmp_en_i) begin
      word_o = '0;
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        if (hit_o[w]) begin
          word_o = word_o | way_word[w];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- design/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_ctrl (
  input  wire                      clk_i,
  input  wire                      rst_ni,
  // flush pulse and enable level
  input  wire                      flush_i,
  input  wire                      en_i,
  // fetch side
  input  wire                      fetch_req_i,
  input  wire icache_pkg::addr_t   fetch_addr_i,
  output logic                     fetch_ready_o,
  output logic                     fetch_valid_o,
  output icache_pkg::addr_t        fetch_addr_o,
  // refill side
  output logic                     mem_req_o,
  output icache_pkg::mem_req_t     mem_data_o,
  input  wire                      mem_ack_i,
  input  wire                      mem_rtrn_vld_i,
  // status from the arrays
  input  wire icache_pkg::way_oh_t hit_i,
  input  wire                      flush_done_i,
  // array control
  output logic                     cache_rden_o,
  output logic                     cache_wren_o,
  output logic                     flush_en_o,
  output icache_pkg::index_t       index_o,
  output icache_pkg::tag_t         tag_o,
  output icache_pkg::offset_t      offset_o,
  output logic                     cmp_en_o,
  // performance counter
  output logic                     miss_o
);

  icache_pkg::ctrl_state_e state_d, state_q;
  icache_pkg::addr_t       addr_d, addr_q;
  icache_pkg::addr_t       req_paddr;
  logic                    cache_en_d, cache_en_q;
  logic                    flush_d, flush_q;
  logic                    cmp_en_d, cmp_en_q;
  logic                    accept;
  logic                    is_nc;
  logic                    lookup_hit;
  logic                    hold_off;

  ////////////////////
  // address plumbing
  ////////////////////

  // latch the fetch address on acceptance and hold it through a miss
  assign accept = fetch_ready_o & fetch_req_i;
  assign addr_d = accept ? fetch_addr_i : addr_q;

  // index comes from the new address so the arrays read in the accept cycle
  assign index_o = addr_d[`ICACHE_INDEX_WIDTH+`ICACHE_OFFSET_WIDTH-1:`ICACHE_OFFSET_WIDTH];
  // tag and offset are only needed one cycle later
  assign tag_o = addr_q[`ICACHE_ADDR_WIDTH-1:`ICACHE_INDEX_WIDTH+`ICACHE_OFFSET_WIDTH];
  assign offset_o = {addr_q[`ICACHE_OFFSET_WIDTH-1:2], 2'b00};
  assign fetch_addr_o = {addr_q[`ICACHE_ADDR_WIDTH-1:2], 2'b00};
  assign cmp_en_o = cmp_en_q;

  // a disabled cache bypasses with one word per request
  assign is_nc = ~cache_en_q;
  assign req_paddr = is_nc ? {addr_q[`ICACHE_ADDR_WIDTH-1:2], 2'b00} :
                             {addr_q[`ICACHE_ADDR_WIDTH-1:`ICACHE_OFFSET_WIDTH],
                              {`ICACHE_OFFSET_WIDTH{1'b0}}};
  assign mem_data_o = '{paddr: req_paddr, nc: is_nc};

  // tag compare only counts when it was armed by a cacheable lookup
  assign lookup_hit = cmp_en_q & cache_en_q & (|hit_i);

  // pending flush or a fresh enable keeps new requests out
  assign hold_off = flush_q | flush_i | (en_i & ~cache_en_q);

  ////////////////////
  // controller FSM
  ////////////////////

  always_comb begin
    state_d       = state_q;
    // turning off works at once while turning on waits for a flush
    cache_en_d    = cache_en_q & en_i;
    flush_d       = flush_q | flush_i;
    cmp_en_d      = 1'b0;
    flush_en_o    = 1'b0;
    cache_rden_o  = 1'b0;
    cache_wren_o  = 1'b0;
    fetch_ready_o = 1'b0;
    fetch_valid_o = 1'b0;
    mem_req_o     = 1'b0;
    miss_o        = 1'b0;

    unique case (state_q)
      // walk all sets and clear their valid bits
      icache_pkg::FLUSH: begin
        flush_en_o = 1'b1;
        if (flush_done_i) begin
          state_d    = icache_pkg::IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      icache_pkg::IDLE: begin
        if (hold_off) begin
          state_d = icache_pkg::FLUSH;
        end else begin
          fetch_ready_o = 1'b1;
          if (fetch_req_i) begin
            cache_rden_o = 1'b1;
            cmp_en_d     = cache_en_q;
            state_d      = icache_pkg::READ;
          end
        end
      end
      // arrays are valid now
      // a bypass access always takes the miss path
      icache_pkg::READ: begin
        if (lookup_hit) begin
          fetch_valid_o = 1'b1;
          state_d       = icache_pkg::IDLE;
          // back to back hits unless a flush is waiting
          if (!hold_off) begin
            fetch_ready_o = 1'b1;
            if (fetch_req_i) begin
              cache_rden_o = 1'b1;
              cmp_en_d     = cache_en_q;
              state_d      = icache_pkg::READ;
            end
          end
        end else begin
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = ~is_nc;
            state_d = icache_pkg::MISS;
          end
        end
      end
      // refill returns in one beat
      icache_pkg::MISS: begin
        if (mem_rtrn_vld_i) begin
          fetch_valid_o = 1'b1;
          cache_wren_o  = ~is_nc;
          state_d       = icache_pkg::IDLE;
        end
      end
      default: begin
        state_d = icache_pkg::FLUSH;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= icache_pkg::FLUSH;
      cache_en_q <= 1'b0;
      flush_q    <= 1'b0;
      cmp_en_q   <= 1'b0;
    end else begin
      state_q    <= state_d;
      cache_en_q <= cache_en_d;
      flush_q    <= flush_d;
      cmp_en_q   <= cmp_en_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
  end

endmodule

`default_nettype wire

//--- design/icache_pkg.sv
`default_nettype none

`include "icache_params.svh"

package icache_pkg;

  // address and its fields
  typedef logic [`ICACHE_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`ICACHE_TAG_WIDTH-1:0] tag_t;
  typedef logic [`ICACHE_INDEX_WIDTH-1:0] index_t;
  typedef logic [`ICACHE_OFFSET_WIDTH-1:0] offset_t;

  // way numbering, binary and one-hot / per-way mask
  typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_t;
  typedef logic [`ICACHE_WAYS-1:0] way_oh_t;

  // payload
  typedef logic [`ICACHE_LINE_WIDTH-1:0] line_t;
  typedef logic [`ICACHE_FETCH_WIDTH-1:0] word_t;

  // controller states
  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } ctrl_state_e;

  // word returned to the fetch unit with its aligned address
  typedef struct packed {
    word_t data;
    addr_t addr;
  } fetch_rsp_t;

  // refill request, nc marks a single-word bypass access
  typedef struct packed {
    addr_t paddr;
    logic  nc;
  } mem_req_t;

endpackage

`default_nettype wire

//--- design/icache_repl.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_repl (
  input  wire                      clk_i,
  input  wire                      rst_ni,
  // valid bits of the looked-up set
  input  wire icache_pkg::way_oh_t valid_i,
  input  wire                      cmp_en_i,
  input  wire                      cache_wren_i,
  output icache_pkg::way_oh_t      victim_oh_o
);

  logic [7:0]          lfsr_q;
  logic                lfsr_fb;
  logic                all_valid;
  logic                update_lfsr;
  icache_pkg::way_t    inv_way;
  icache_pkg::way_t    rnd_way;
  icache_pkg::way_t    victim;
  icache_pkg::way_oh_t victim_oh_q;

  // lowest numbered invalid way wins
  always_comb begin
    inv_way = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        inv_way = icache_pkg::way_t'(w);
      end
    end
  end

  assign all_valid = &valid_i;

  // x^8 + x^6 + x^5 + x^4 + 1, maximal length
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
  // only step when a full set really loses a line
  assign update_lfsr = cache_wren_i & all_valid;
  assign rnd_way = lfsr_q[$bits(icache_pkg::way_t)-1:0];
  assign victim = all_valid ? rnd_way : inv_way;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q      <= `ICACHE_LFSR_SEED;
      victim_oh_q <= '0;
    end else begin
      if (update_lfsr) begin
        lfsr_q <= {lfsr_q[6:0], lfsr_fb};
      end
      // held from the compare until the refill writes
      if (cmp_en_i) begin
        victim_oh_q <= icache_pkg::way_oh_t'(1) << victim;
      end
    end
  end

  assign victim_oh_o = victim_oh_q;

endmodule

`default_nettype wire

//--- design/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top (
  input  wire                       clk_i,
  input  wire                       rst_ni,
  input  wire                       flush_i,
  input  wire                       en_i,
  // fetch side
  input  wire                       fetch_req_i,
  input  wire icache_pkg::addr_t    fetch_addr_i,
  output logic                      fetch_ready_o,
  output logic                      fetch_valid_o,
  output icache_pkg::fetch_rsp_t    fetch_rsp_o,
  // refill side
  output logic                      mem_req_o,
  output icache_pkg::mem_req_t      mem_data_o,
  input  wire                       mem_ack_i,
  input  wire                       mem_rtrn_vld_i,
  input  wire icache_pkg::line_t    mem_rtrn_data_i,
  // to the performance counter
  output logic                      miss_o
);

  logic                cache_rden;
  logic                cache_wren;
  logic                flush_en;
  logic                flush_done;
  logic                cmp_en_q;
  icache_pkg::index_t  index;
  icache_pkg::tag_t    tag_q;
  icache_pkg::offset_t offset_q;
  icache_pkg::way_oh_t hit;
  icache_pkg::way_oh_t valid;
  icache_pkg::way_oh_t victim_oh;
  icache_pkg::word_t   word;
  icache_pkg::addr_t   rsp_addr;

  // fetched word travels with the aligned fetch address
  assign fetch_rsp_o = '{data: word, addr: rsp_addr};

  icache_ctrl i_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .en_i           (en_i),
    .fetch_req_i    (fetch_req_i),
    .fetch_addr_i   (fetch_addr_i),
    .fetch_ready_o  (fetch_ready_o),
    .fetch_valid_o  (fetch_valid_o),
    .fetch_addr_o   (rsp_addr),
    .mem_req_o      (mem_req_o),
    .mem_data_o     (mem_data_o),
    .mem_ack_i      (mem_ack_i),
    .mem_rtrn_vld_i (mem_rtrn_vld_i),
    .hit_i          (hit),
    .flush_done_i   (flush_done),
    .cache_rden_o   (cache_rden),
    .cache_wren_o   (cache_wren),
    .flush_en_o     (flush_en),
    .index_o        (index),
    .tag_o          (tag_q),
    .offset_o       (offset_q),
    .cmp_en_o       (cmp_en_q),
    .miss_o         (miss_o)
  );

  icache_arrays i_arrays (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cache_rden_i (cache_rden),
    .cache_wren_i (cache_wren),
    .flush_en_i   (flush_en),
    .index_i      (index),
    .tag_i        (tag_q),
    .offset_i     (offset_q),
    .cmp_en_i     (cmp_en_q),
    .victim_oh_i  (victim_oh),
    .rtrn_data_i  (mem_rtrn_data_i),
    .hit_o        (hit),
    .valid_o      (valid),
    .flush_done_o (flush_done),
    .word_o       (word)
  );

  icache_repl i_repl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .valid_i      (valid),
    .cmp_en_i     (cmp_en_q),
    .cache_wren_i (cache_wren),
    .victim_oh_o  (victim_oh)
  );

endmodule

`default_nettype wire

//--- icache.f
+incdir+include
design/icache_pkg.sv
design/icache_ctrl.sv
design/icache_arrays.sv
design/icache_repl.sv
design/icache_top.sv
sim/tb_icache.sv

//--- include/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// physical fetch address, translation is not part of this cache
`define ICACHE_ADDR_WIDTH 32

// geometry
// 4 ways of 16 sets with 16 byte lines gives a 1 KiB cache
`define ICACHE_WAYS 4
`define ICACHE_SETS 16
`define ICACHE_LINE_WIDTH 128

// instruction word delivered per fetch
`define ICACHE_FETCH_WIDTH 32

// address split
// tag | index | byte offset
`define ICACHE_OFFSET_WIDTH 4
`define ICACHE_INDEX_WIDTH 4
`define ICACHE_TAG_WIDTH 24

// start value of the replacement lfsr
// must not be zero or the lfsr locks up
`define ICACHE_LFSR_SEED 8'hA5

`endif

//--- sim/tb_icache.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module tb_icache;

  localparam int TIMEOUT = 200;

  logic                   clk_i = 1'b0;
  logic                   rst_ni;
  logic                   flush_i;
  logic                   en_i;
  logic                   fetch_req_i;
  icache_pkg::addr_t      fetch_addr_i;
  logic                   fetch_ready_o;
  logic                   fetch_valid_o;
  icache_pkg::fetch_rsp_t fetch_rsp_o;
  logic                   mem_req_o;
  icache_pkg::mem_req_t   mem_data_o;
  logic                   mem_ack_i;
  logic                   mem_rtrn_vld_i;
  icache_pkg::line_t      mem_rtrn_data_i;
  logic                   miss_o;

  // memory contents are address ^ generation, a new generation models changed code
  icache_pkg::addr_t      gen;
  integer                 seed = 32'h8f4e_1e61;
  icache_pkg::addr_t      exp_q[$];
  icache_pkg::mem_req_t   last_req;
  int                     req_cnt = 0;
  int                     miss_cnt = 0;

  always #10 clk_i = ~clk_i;

  icache_top dut0 (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .en_i            (en_i),
    .fetch_req_i     (fetch_req_i),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_ready_o   (fetch_ready_o),
    .fetch_valid_o   (fetch_valid_o),
    .fetch_rsp_o     (fetch_rsp_o),
    .mem_req_o       (mem_req_o),
    .mem_data_o      (mem_data_o),
    .mem_ack_i       (mem_ack_i),
    .mem_rtrn_vld_i  (mem_rtrn_vld_i),
    .mem_rtrn_data_i (mem_rtrn_data_i),
    .miss_o          (miss_o)
  );

  task automatic report_fail();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      report_fail();
    end
  endtask

  // reference line, word i sits at bits [32*i +: 32]
  function automatic icache_pkg::line_t mem_line(input icache_pkg::addr_t paddr);
    icache_pkg::line_t line;
    icache_pkg::addr_t base;
    base = {paddr[`ICACHE_ADDR_WIDTH-1:`ICACHE_OFFSET_WIDTH], {`ICACHE_OFFSET_WIDTH{1'b0}}};
    for (int i = 0; i < 4; i++) begin
      line[i*32 +: 32] = (base + icache_pkg::addr_t'(4 * i)) ^ gen;
    end
    return line;
  endfunction

  function automatic icache_pkg::word_t expected_word(input icache_pkg::addr_t a);
    icache_pkg::line_t line;
    line = mem_line(a);
    return line[int'(a[3:2]) * `ICACHE_FETCH_WIDTH +: `ICACHE_FETCH_WIDTH];
  endfunction

  ////////////////////
  // memory model
  ////////////////////

  // ack after 0..3 cycles, whole line back 1..5 cycles after the ack
  initial begin : mem_model
    int dly;
    icache_pkg::mem_req_t req_now;
    mem_ack_i       = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_data_i = '0;
    forever begin
      @(negedge clk_i);
      mem_rtrn_vld_i = 1'b0;
      if (mem_req_o) begin
        req_now  = mem_data_o;
        last_req = mem_data_o;
        req_cnt  = req_cnt + 1;
        dly = $unsigned($random(seed)) % 4;
        // request must stay up and unchanged until acked
        repeat (dly) begin
          @(negedge clk_i);
          assert (mem_req_o) else begin
            $display("mem_req_o dropped at %0t before mem_ack_i", $time);
            report_fail();
          end
          check_value("mem_data_o.paddr", mem_data_o.paddr, req_now.paddr);
        end
        mem_ack_i = 1'b1;
        @(negedge clk_i);
        mem_ack_i = 1'b0;
        dly = 1 + $unsigned($random(seed)) % 5;
        repeat (dly - 1) @(negedge clk_i);
        mem_rtrn_data_i = mem_line(req_now.paddr);
        mem_rtrn_vld_i  = 1'b1;
      end
    end
  end

  always @(posedge clk_i) begin
    if (miss_o) begin
      miss_cnt <= miss_cnt + 1;
    end
  end

  // every response against the reference, in request order
  always @(posedge clk_i) begin : rsp_checker
    icache_pkg::addr_t a;
    if (fetch_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("fetch_valid_o at %0t without an outstanding fetch", $time);
        report_fail();
      end else begin
        a = exp_q.pop_front();
        check_value("fetch_rsp_o.data", fetch_rsp_o.data, expected_word(a));
        check_value("fetch_rsp_o.addr", fetch_rsp_o.addr, {a[31:2], 2'b00});
      end
    end
  end

  // one fetch, lat counts cycles from acceptance to fetch_valid_o
  task automatic run_fetch(input icache_pkg::addr_t a, output int lat,
                           output int nreq, output int nmiss);
    int req0;
    int miss0;
    int n;
    @(negedge clk_i);
    req0 = req_cnt;
    miss0 = miss_cnt;
    exp_q.push_back(a);
    fetch_req_i  = 1'b1;
    fetch_addr_i = a;
    n = 0;
    @(posedge clk_i);
    while (!fetch_ready_o) begin
      n++;
      if (n > TIMEOUT) begin
        $display("fetch of %h was never accepted", a);
        report_fail();
      end
      @(posedge clk_i);
    end
    @(negedge clk_i);
    fetch_req_i = 1'b0;
    lat = 1;
    @(posedge clk_i);
    while (!fetch_valid_o) begin
      lat++;
      if (lat > TIMEOUT) begin
        $display("fetch of %h never returned fetch_valid_o", a);
        report_fail();
      end
      @(posedge clk_i);
    end
    @(negedge clk_i);
    nreq = req_cnt - req0;
    nmiss = miss_cnt - miss0;
  endtask

  ////////////////////
  // scenarios
  ////////////////////

  initial begin : stimulus
    int lat;
    int nreq;
    int nmiss;
    int total;
    int n;
    icache_pkg::addr_t a;
    rst_ni       = 1'b0;
    flush_i      = 1'b0;
    en_i         = 1'b1;
    fetch_req_i  = 1'b0;
    fetch_addr_i = '0;
    gen          = 32'h5a5a_0000;
    repeat (4) begin
      @(negedge clk_i);
      assert (!fetch_ready_o && !fetch_valid_o && !mem_req_o && !miss_o) else begin
        $display("outputs not quiet during reset at %0t", $time);
        report_fail();
      end
    end
    rst_ni = 1'b1;

    // enable flush after reset walks every set once
    n = 0;
    @(posedge clk_i);
    while (!fetch_ready_o) begin
      n++;
      if (n > TIMEOUT) begin
        $display("fetch_ready_o never rose after reset");
        report_fail();
      end
      @(posedge clk_i);
    end
    assert (n == `ICACHE_SETS) else begin
      $display("fetch_ready_o low for %0d cycles after reset, expected %0d", n, `ICACHE_SETS);
      report_fail();
    end

    // cold miss then hits on the same line
    run_fetch(32'h0000_1048, lat, nreq, nmiss);
    assert (nreq == 1 && nmiss == 1) else begin
      $display("cold fetch gave %0d requests and %0d misses", nreq, nmiss);
      report_fail();
    end
    check_value("mem_data_o.paddr", last_req.paddr, 32'h0000_1040);
    check_value("mem_data_o.nc", {31'b0, last_req.nc}, 32'd0);
    run_fetch(32'h0000_104c, lat, nreq, nmiss);
    assert (nreq == 0 && lat == 1) else begin
      $display("cached fetch took %0d cycles with %0d requests", lat, nreq);
      report_fail();
    end

    // six lines into set 9, more than the ways can hold
    for (int k = 0; k < 6; k++) begin
      a = icache_pkg::addr_t'(32'h0003_0094 + 32'h1000 * k);
      run_fetch(a, lat, nreq, nmiss);
      assert (nreq == 1) else begin
        $display("first fetch of %h gave %0d requests", a, nreq);
        report_fail();
      end
    end
    total = 0;
    for (int k = 0; k < 6; k++) begin
      a = icache_pkg::addr_t'(32'h0003_0094 + 32'h1000 * k);
      run_fetch(a, lat, nreq, nmiss);
      total += nmiss;
    end
    assert (total >= 1) else begin
      $display("refetch of an overfull set never missed");
      report_fail();
    end

    // flush, then the memory changes under the old line
    @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    gen = 32'hc3c3_0000;
    run_fetch(32'h0000_1048, lat, nreq, nmiss);
    assert (nreq == 1 && nmiss == 1) else begin
      $display("fetch after flush gave %0d requests and %0d misses", nreq, nmiss);
      report_fail();
    end
    run_fetch(32'h0000_1048, lat, nreq, nmiss);
    assert (nreq == 0 && lat == 1) else begin
      $display("refilled line after flush did not hit");
      report_fail();
    end

    // disabled cache bypasses with word requests, even for a cached line
    @(negedge clk_i);
    en_i = 1'b0;
    repeat (2) @(negedge clk_i);
    repeat (2) begin
      run_fetch(32'h0000_1044, lat, nreq, nmiss);
      assert (nreq == 1 && nmiss == 0) else begin
        $display("bypass fetch gave %0d requests and %0d misses", nreq, nmiss);
        report_fail();
      end
      check_value("mem_data_o.paddr", last_req.paddr, 32'h0000_1044);
      check_value("mem_data_o.nc", {31'b0, last_req.nc}, 32'd1);
    end

    repeat (2) @(negedge clk_i);
    if (exp_q.size() == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("%0d fetch responses never arrived", exp_q.size());
      report_fail();
    end
  end

endmodule

`default_nettype wire
